// File: bench/mesh_properties.sv
`timescale 1ns/10ps

module mesh_properties
  import mesh_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input packet_t south_data_i [num_tiles_x_lp],
  input logic    south_v_i    [num_tiles_x_lp],
  input logic    south_yumi_i [num_tiles_x_lp]
);

  bit warm_r   = 1'b0;  // first edge still sees pre-reset state
  int failures = 0;     // failed assertions so far

  always @(posedge clk)
    warm_r <= 1'b1;

  for (genvar c = 0; c < num_tiles_x_lp; c++)
  begin : g_col
    a_hold: assert property (@(posedge clk) disable iff (reset)
      south_v_i[c] && !south_yumi_i[c] |=> south_v_i[c] && $stable(south_data_i[c]))
    else
    begin
      failures++;
      $error("south column %0d dropped or changed a packet before yumi", c);
    end

    a_yumi_needs_valid: assert property (@(posedge clk) disable iff (reset)
      south_yumi_i[c] |-> south_v_i[c])
    else
    begin
      failures++;
      $error("yumi on south column %0d without valid", c);
    end

    a_quiet_in_reset: assert property (@(posedge clk)
      reset && warm_r |-> !south_v_i[c])
    else
    begin
      failures++;
      $error("south column %0d valid during reset", c);
    end

    a_reply_only: assert property (@(posedge clk) disable iff (reset)
      south_v_i[c] |-> south_data_i[c].op == op_reply)
    else
    begin
      failures++;
      $error("south column %0d carries a packet that is not a reply", c);
    end
  end

endmodule

bind mesh_top mesh_properties i_props
(
  .clk          (clk),
  .reset        (reset),
  .south_data_i (south_data_o),
  .south_v_i    (south_v_o),
  .south_yumi_i (south_yumi_i)
);

// File: bench/tb_mesh_top.sv
`timescale 1ns/10ps

module tb_mesh_top
  import mesh_pkg::*;
();

  logic                     clk;
  logic                     reset;
  logic [addr_width_lp-1:0] image_addr;
  logic [data_width_lp-1:0] image_data;
  packet_t                  south_data [num_tiles_x_lp];
  logic                     south_v    [num_tiles_x_lp];
  logic                     south_yumi [num_tiles_x_lp];
  logic                     load_done;

  logic [data_width_lp-1:0] rom [image_words_lp];
  bit                       seen [image_words_lp];  // one scoreboard flag per image word
  integer                   seed;
  int                       received;
  int                       mismatches;
  int                       other_errors;
  bit                       late_valid_seen;

  mesh_top i_dut
  (
    .clk          (clk),
    .reset        (reset),
    .image_addr_o (image_addr),
    .image_data_i (image_data),
    .south_data_o (south_data),
    .south_v_o    (south_v),
    .south_yumi_i (south_yumi),
    .load_done_o  (load_done)
  );

  assign image_data = rom[image_addr];  // combinational ROM

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      mismatches++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic print_counts();
    $display("mismatches=%0d other_errors=%0d assertion_failures=%0d replies=%0d/%0d",
             mismatches, other_errors, i_dut.i_props.failures, received, image_words_lp);
  endtask

  task automatic record_reply(input int col, input packet_t pkt);
    if (pkt.addr >= image_words_lp)
    begin
      other_errors++;
      $display("reply on column %0d carries addr %0d, outside the image", col, pkt.addr);
    end
    else
    begin
      check_value("reply data", rom[pkt.addr], pkt.data);
      // owning tile is addr mod 4 in row major order
      check_value("reply column", (pkt.addr % num_tiles_lp) % num_tiles_x_lp, col);
      if (seen[pkt.addr])
      begin
        other_errors++;
        $display("duplicate reply for addr %0d on column %0d", pkt.addr, col);
      end
      else
      begin
        seen[pkt.addr] = 1'b1;
        received++;
      end
    end
  endtask

  // random back-pressure with yumi offered only while valid
  always @(posedge clk)
  begin
    #1;
    for (int c = 0; c < num_tiles_x_lp; c++)
    begin
      if (reset)
        south_yumi[c] = 1'b0;
      else
        south_yumi[c] = south_v[c] && (($random(seed) & 3) != 0);
    end
  end

  // a valid/yumi pair seen mid-cycle transfers on the next edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      for (int c = 0; c < num_tiles_x_lp; c++)
      begin
        if (south_v[c] && received == image_words_lp && !late_valid_seen)
        begin
          late_valid_seen = 1'b1;
          other_errors++;
          $display("south valid on column %0d after all replies were received", c);
        end
        if (south_v[c] && south_yumi[c])
          record_reply(c, south_data[c]);
      end
    end
  end

  initial
  begin
    repeat (image_words_lp * 2 * 40) @(posedge clk);
    $display("timeout: only %0d of %0d replies arrived in time", received, image_words_lp);
    print_counts();
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    seed            = 92238;
    clk             = 1'b0;
    reset           = 1'b1;
    received        = 0;
    mismatches      = 0;
    other_errors    = 0;
    late_valid_seen = 1'b0;
    for (int c = 0; c < num_tiles_x_lp; c++)
      south_yumi[c] = 1'b0;
    for (int i = 0; i < image_words_lp; i++)
    begin
      rom[i]  = $random(seed);
      seen[i] = 1'b0;
    end

    repeat (10) @(posedge clk);
    #1 reset = 1'b0;

    wait (received == image_words_lp);
    repeat (50) @(negedge clk);  // quiet period in which the sampler catches late valids
    check_value("load done", 1, load_done);

    print_counts();
    if (mismatches == 0 && other_errors == 0 && i_dut.i_props.failures == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: common/mesh_pkg.sv
package mesh_pkg;

  localparam int num_tiles_x_lp    = 2;
  localparam int num_tiles_y_lp    = 2;
  localparam int num_tiles_lp      = num_tiles_x_lp * num_tiles_y_lp;
  localparam int x_width_lp        = 1;
  localparam int y_width_lp        = 2;  // wide enough to name the exit row below the array
  localparam int data_width_lp     = 32;
  localparam int addr_width_lp     = 16;
  localparam int bank_words_lp     = 16;
  localparam int bank_idx_width_lp = $clog2(bank_words_lp);
  localparam int image_words_lp    = 64;
  localparam int fifo_els_lp       = 2;

  typedef enum logic [1:0] {op_store, op_read, op_reply} mesh_op_e;

  // router port order, local port first
  typedef enum logic [2:0] {P, W, E, N, S} dir_e;

  typedef struct packed {
    mesh_op_e                 op;
    logic [x_width_lp-1:0]    dest_x;
    logic [y_width_lp-1:0]    dest_y;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
  } packet_t;

  // words are interleaved over the tiles in row major order
  function automatic logic [x_width_lp-1:0] home_x_f(input logic [addr_width_lp-1:0] addr);
    int unsigned tile;
    tile = addr % num_tiles_lp;
    return x_width_lp'(tile % num_tiles_x_lp);
  endfunction

  function automatic logic [y_width_lp-1:0] home_y_f(input logic [addr_width_lp-1:0] addr);
    int unsigned tile;
    tile = addr % num_tiles_lp;
    return y_width_lp'(tile / num_tiles_x_lp);
  endfunction

  function automatic logic [bank_idx_width_lp-1:0] bank_idx_f(
    input logic [addr_width_lp-1:0] addr
  );
    return bank_idx_width_lp'(addr / num_tiles_lp);
  endfunction

endpackage

// File: mesh_top.f
common/mesh_pkg.sv
rtl/mesh_fifo.sv
router/mesh_router.sv
tile/mesh_tile.sv
rtl/tile_array.sv
rtl/packet_loader.sv
rtl/mesh_top.sv
bench/mesh_properties.sv
bench/tb_mesh_top.sv

// File: router/mesh_router.sv
`timescale 1ns/10ps

module mesh_router
  import mesh_pkg::*;
#(
  parameter logic [x_width_lp-1:0] x_cord_p = '0,
  parameter logic [y_width_lp-1:0] y_cord_p = '0
)
(
  input  logic    clk,
  input  logic    reset,
  input  packet_t data_i  [P:S],
  input  logic    v_i     [P:S],
  output logic    ready_o [P:S],
  output packet_t data_o  [P:S],
  output logic    v_o     [P:S],
  input  logic    yumi_i  [P:S]
);

  packet_t    q_data [P:S];
  logic       q_v    [P:S];
  logic       q_deq  [P:S];
  dir_e       q_dir  [P:S];
  logic [2:0] gnt    [P:S];  // granted input per output
  logic       gnt_v  [P:S];
  logic [2:0] ptr_r  [P:S];  // round-robin start point per output

  for (genvar i = P; i <= S; i++)
  begin : g_in
    mesh_fifo i_fifo
    (
      .clk     (clk),
      .reset   (reset),
      .data_i  (data_i[i]),
      .v_i     (v_i[i]),
      .ready_o (ready_o[i]),
      .data_o  (q_data[i]),
      .v_o     (q_v[i]),
      .yumi_i  (q_deq[i])
    );
  end

  // x first, then y
  always_comb
  begin
    for (int i = P; i <= S; i++)
    begin
      if (q_data[i].dest_x > x_cord_p)
        q_dir[i] = E;
      else if (q_data[i].dest_x < x_cord_p)
        q_dir[i] = W;
      else if (q_data[i].dest_y > y_cord_p)
        q_dir[i] = S;
      else if (q_data[i].dest_y < y_cord_p)
        q_dir[i] = N;
      else
        q_dir[i] = P;
    end
  end

  always_comb
  begin
    int cand;
    for (int o = P; o <= S; o++)
    begin
      gnt[o]   = ptr_r[o];
      gnt_v[o] = 1'b0;
      for (int k = 0; k <= S; k++)
      begin
        cand = (ptr_r[o] + k) % (S + 1);
        if (!gnt_v[o] && q_v[cand] && q_dir[cand] == o)
        begin
          gnt[o]   = 3'(cand);
          gnt_v[o] = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    for (int i = P; i <= S; i++)
      q_deq[i] = 1'b0;
    for (int o = P; o <= S; o++)
      if (gnt_v[o] && yumi_i[o])
        q_deq[gnt[o]] = 1'b1;
  end

  for (genvar o = P; o <= S; o++)
  begin : g_out
    assign v_o[o]    = gnt_v[o];
    assign data_o[o] = q_data[gnt[o]];

    // parking the pointer on a stalled grant keeps the output stable until yumi
    always_ff @(posedge clk)
    begin
      if (reset)
        ptr_r[o] <= '0;
      else if (gnt_v[o])
      begin
        if (yumi_i[o])
          ptr_r[o] <= (gnt[o] == 3'(S)) ? 3'd0 : gnt[o] + 3'd1;
        else
          ptr_r[o] <= gnt[o];
      end
    end
  end

endmodule

// File: rtl/mesh_fifo.sv
`timescale 1ns/10ps

module mesh_fifo
  import mesh_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  packet_t data_i,
  input  logic    v_i,
  output logic    ready_o,
  output packet_t data_o,
  output logic    v_o,
  input  logic    yumi_i
);

  packet_t                              mem_r [fifo_els_lp];
  logic [$clog2(fifo_els_lp)-1:0]       wr_ptr_r;
  logic [$clog2(fifo_els_lp)-1:0]       rd_ptr_r;
  logic [$clog2(fifo_els_lp + 1)-1:0]   count_r;
  logic                                 enq;
  logic                                 deq;

  assign ready_o = (count_r != fifo_els_lp);
  assign v_o     = (count_r != 0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= (wr_ptr_r == fifo_els_lp - 1) ? '0 : wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= (rd_ptr_r == fifo_els_lp - 1) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_r + enq - deq;  // both may happen on one edge
    end
  end

endmodule

// File: rtl/mesh_top.sv
`timescale 1ns/10ps

module mesh_top
  import mesh_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  output logic [addr_width_lp-1:0] image_addr_o,
  input  logic [data_width_lp-1:0] image_data_i,
  output packet_t                  south_data_o [num_tiles_x_lp],
  output logic                     south_v_o    [num_tiles_x_lp],
  input  logic                     south_yumi_i [num_tiles_x_lp],
  output logic                     load_done_o
);

  packet_t inj_packet;
  logic    inj_v;
  logic    inj_ready;

  packet_loader i_loader
  (
    .clk          (clk),
    .reset        (reset),
    .image_addr_o (image_addr_o),
    .image_data_i (image_data_i),
    .packet_o     (inj_packet),
    .v_o          (inj_v),
    .ready_i      (inj_ready),
    .load_done_o  (load_done_o)
  );

  // everything enters through the west side of tile (0,0)
  tile_array i_array
  (
    .clk          (clk),
    .reset        (reset),
    .west_data_i  (inj_packet),
    .west_v_i     (inj_v),
    .west_ready_o (inj_ready),
    .south_data_o (south_data_o),
    .south_v_o    (south_v_o),
    .south_yumi_i (south_yumi_i)
  );

endmodule

// File: rtl/packet_loader.sv
`timescale 1ns/10ps

module packet_loader
  import mesh_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  output logic [addr_width_lp-1:0] image_addr_o,
  input  logic [data_width_lp-1:0] image_data_i,
  output packet_t                  packet_o,
  output logic                     v_o,
  input  logic                     ready_i,
  output logic                     load_done_o
);

  typedef enum logic [1:0] {ph_store, ph_read, ph_done} phase_e;

  phase_e                   phase_r;
  logic [addr_width_lp-1:0] count_r;
  logic                     last_word;

  assign last_word    = (count_r == addr_width_lp'(image_words_lp - 1));
  assign image_addr_o = count_r;

  assign v_o         = ~reset & (phase_r != ph_done);
  assign load_done_o = (phase_r == ph_done);

  // stores carry the image word and reads only need the address
  assign packet_o.op     = (phase_r == ph_store) ? op_store : op_read;
  assign packet_o.dest_x = home_x_f(count_r);
  assign packet_o.dest_y = home_y_f(count_r);
  assign packet_o.addr   = count_r;
  assign packet_o.data   = (phase_r == ph_store) ? image_data_i : '0;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase_r <= ph_store;
      count_r <= '0;
    end
    else if (v_o && ready_i)
    begin
      if (last_word)
      begin
        count_r <= '0;
        phase_r <= (phase_r == ph_store) ? ph_read : ph_done;
      end
      else
        count_r <= count_r + 1'b1;
    end
  end

endmodule

// File: rtl/tile_array.sv
`timescale 1ns/10ps

module tile_array
  import mesh_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  packet_t west_data_i,
  input  logic    west_v_i,
  output logic    west_ready_o,
  output packet_t south_data_o [num_tiles_x_lp],
  output logic    south_v_o    [num_tiles_x_lp],
  input  logic    south_yumi_i [num_tiles_x_lp]
);

  packet_t t_data_i  [num_tiles_y_lp][num_tiles_x_lp][W:S];
  logic    t_v_i     [num_tiles_y_lp][num_tiles_x_lp][W:S];
  logic    t_ready_o [num_tiles_y_lp][num_tiles_x_lp][W:S];
  packet_t t_data_o  [num_tiles_y_lp][num_tiles_x_lp][W:S];
  logic    t_v_o     [num_tiles_y_lp][num_tiles_x_lp][W:S];
  logic    t_yumi_i  [num_tiles_y_lp][num_tiles_x_lp][W:S];

  for (genvar y = 0; y < num_tiles_y_lp; y++)
  begin : g_row
    for (genvar x = 0; x < num_tiles_x_lp; x++)
    begin : g_col
      mesh_tile #(
        .x_cord_p (x_width_lp'(x)),
        .y_cord_p (y_width_lp'(y))
      ) i_tile
      (
        .clk          (clk),
        .reset        (reset),
        .link_data_i  (t_data_i[y][x]),
        .link_v_i     (t_v_i[y][x]),
        .link_ready_o (t_ready_o[y][x]),
        .link_data_o  (t_data_o[y][x]),
        .link_v_o     (t_v_o[y][x]),
        .link_yumi_i  (t_yumi_i[y][x])
      );

      if (x == 0)
      begin : g_w_edge
        // only tile (0,0) takes injected packets
        assign t_data_i[y][x][W] = (y == 0) ? west_data_i : '0;
        assign t_v_i[y][x][W]    = (y == 0) ? west_v_i : 1'b0;
        assign t_yumi_i[y][x][W] = t_v_o[y][x][W];
      end
      else
      begin : g_w_link
        assign t_data_i[y][x][W] = t_data_o[y][x-1][E];
        assign t_v_i[y][x][W]    = t_v_o[y][x-1][E];
        assign t_yumi_i[y][x][W] = t_v_o[y][x][W] & t_ready_o[y][x-1][E];
      end

      if (x == num_tiles_x_lp - 1)
      begin : g_e_edge
        assign t_data_i[y][x][E] = '0;
        assign t_v_i[y][x][E]    = 1'b0;
        assign t_yumi_i[y][x][E] = t_v_o[y][x][E];  // never routed here
      end
      else
      begin : g_e_link
        assign t_data_i[y][x][E] = t_data_o[y][x+1][W];
        assign t_v_i[y][x][E]    = t_v_o[y][x+1][W];
        assign t_yumi_i[y][x][E] = t_v_o[y][x][E] & t_ready_o[y][x+1][W];
      end

      if (y == 0)
      begin : g_n_edge
        assign t_data_i[y][x][N] = '0;
        assign t_v_i[y][x][N]    = 1'b0;
        assign t_yumi_i[y][x][N] = t_v_o[y][x][N];
      end
      else
      begin : g_n_link
        assign t_data_i[y][x][N] = t_data_o[y-1][x][S];
        assign t_v_i[y][x][N]    = t_v_o[y-1][x][S];
        assign t_yumi_i[y][x][N] = t_v_o[y][x][N] & t_ready_o[y-1][x][S];
      end

      if (y == num_tiles_y_lp - 1)
      begin : g_s_exit
        assign t_data_i[y][x][S] = '0;
        assign t_v_i[y][x][S]    = 1'b0;
        assign t_yumi_i[y][x][S] = south_yumi_i[x];
        assign south_data_o[x]   = t_data_o[y][x][S];
        assign south_v_o[x]      = t_v_o[y][x][S];
      end
      else
      begin : g_s_link
        assign t_data_i[y][x][S] = t_data_o[y+1][x][N];
        assign t_v_i[y][x][S]    = t_v_o[y+1][x][N];
        assign t_yumi_i[y][x][S] = t_v_o[y][x][S] & t_ready_o[y+1][x][N];
      end
    end
  end

  assign west_ready_o = t_ready_o[0][0][W];

endmodule

// File: tile/mesh_tile.sv
`timescale 1ns/10ps

module mesh_tile
  import mesh_pkg::*;
#(
  parameter logic [x_width_lp-1:0] x_cord_p = '0,
  parameter logic [y_width_lp-1:0] y_cord_p = '0
)
(
  input  logic    clk,
  input  logic    reset,
  input  packet_t link_data_i  [W:S],
  input  logic    link_v_i     [W:S],
  output logic    link_ready_o [W:S],
  output packet_t link_data_o  [W:S],
  output logic    link_v_o     [W:S],
  input  logic    link_yumi_i  [W:S]
);

  logic [data_width_lp-1:0]     bank_r [bank_words_lp];

  packet_t                      r_data_i  [P:S];
  logic                         r_v_i     [P:S];
  logic                         r_ready_o [P:S];
  packet_t                      r_data_o  [P:S];
  logic                         r_v_o     [P:S];
  logic                         r_yumi_i  [P:S];

  packet_t                      lcl;
  logic                         lcl_is_read;
  logic [bank_idx_width_lp-1:0] lcl_idx;

  packet_t                      reply_in;
  logic                         reply_v_in;
  logic                         reply_ready;
  packet_t                      reply_out;
  logic                         reply_v_out;

  mesh_router #(
    .x_cord_p (x_cord_p),
    .y_cord_p (y_cord_p)
  ) i_router
  (
    .clk     (clk),
    .reset   (reset),
    .data_i  (r_data_i),
    .v_i     (r_v_i),
    .ready_o (r_ready_o),
    .data_o  (r_data_o),
    .v_o     (r_v_o),
    .yumi_i  (r_yumi_i)
  );

  for (genvar d = W; d <= S; d++)
  begin : g_link
    assign r_data_i[d]     = link_data_i[d];
    assign r_v_i[d]        = link_v_i[d];
    assign link_ready_o[d] = r_ready_o[d];
    assign link_data_o[d]  = r_data_o[d];
    assign link_v_o[d]     = r_v_o[d];
    assign r_yumi_i[d]     = link_yumi_i[d];
  end

  assign lcl         = r_data_o[P];
  assign lcl_is_read = (lcl.op == op_read);
  assign lcl_idx     = bank_idx_f(lcl.addr);

  // reads stall while the reply queue is full
  assign r_yumi_i[P] = r_v_o[P] & (~lcl_is_read | reply_ready);

  always_ff @(posedge clk)
  begin
    if (r_yumi_i[P] && lcl.op == op_store)
      bank_r[lcl_idx] <= lcl.data;
  end

  assign reply_v_in      = r_v_o[P] & lcl_is_read;
  assign reply_in.op     = op_reply;
  assign reply_in.dest_x = x_cord_p;
  assign reply_in.dest_y = y_width_lp'(num_tiles_y_lp);  // exit row below the array
  assign reply_in.addr   = lcl.addr;
  assign reply_in.data   = bank_r[lcl_idx];

  mesh_fifo i_reply_fifo
  (
    .clk     (clk),
    .reset   (reset),
    .data_i  (reply_in),
    .v_i     (reply_v_in),
    .ready_o (reply_ready),
    .data_o  (reply_out),
    .v_o     (reply_v_out),
    .yumi_i  (reply_v_out & r_ready_o[P])
  );

  assign r_data_i[P] = reply_out;
  assign r_v_i[P]    = reply_v_out;

endmodule
